//--- design/simple_system_defines.svh
// Simple system global definitions

`ifndef SIMPLE_SYSTEM_DEFINES_SVH
`define SIMPLE_SYSTEM_DEFINES_SVH

// Bus widths
`define SS_DATA_W 32
`define SS_ADDR_W 32
`define SS_BE_W   4

// Number of bus devices
`define SS_NR_DEVICES 3

// Address map, 1 MB RAM and two 1 kB register windows
`define SS_RAM_BASE     32'h0010_0000
`define SS_RAM_MASK     (~32'h000F_FFFF)
`define SS_SIMCTRL_BASE 32'h0002_0000
`define SS_SIMCTRL_MASK (~32'h0000_03FF)
`define SS_TIMER_BASE   32'h0003_0000
`define SS_TIMER_MASK   (~32'h0000_03FF)

// Default RAM depth in words
`define SS_RAM_WORDS 1024

`endif

//--- design/simple_system_pkg.sv
// Simple system types

package simple_system_pkg;

  // Bus device select, NoDevice marks an unmapped access
  typedef enum logic [1:0] {
    Ram      = 2'd0,
    SimCtrl  = 2'd1,
    Timer    = 2'd2,
    NoDevice = 2'd3
  } bus_device_e;

  // Timer register offsets within its window
  typedef enum logic [9:0] {
    MtimeLo    = 10'h000,
    MtimeHi    = 10'h004,
    MtimecmpLo = 10'h008,
    MtimecmpHi = 10'h00C
  } timer_reg_e;

  // Simulation control register offsets
  typedef enum logic [9:0] {
    CharOut = 10'h000,
    Halt    = 10'h008
  } simctrl_reg_e;

endpackage

//--- design/system_bus.sv
// Address decoding bus

`timescale 1ns/1ps

`include "simple_system_defines.svh"

module system_bus (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  host_req_i,
  input  logic                  host_we_i,
  input  logic [`SS_BE_W-1:0]   host_be_i,
  input  logic [`SS_ADDR_W-1:0] host_addr_i,
  input  logic [`SS_DATA_W-1:0] host_wdata_i,
  output logic                  host_gnt_o,
  output logic                  host_rvalid_o,
  output logic [`SS_DATA_W-1:0] host_rdata_o,
  output logic                  host_err_o,

  output logic                  dev_req_o    [`SS_NR_DEVICES],
  output logic                  dev_we_o,
  output logic [`SS_BE_W-1:0]   dev_be_o,
  output logic [`SS_ADDR_W-1:0] dev_addr_o,
  output logic [`SS_DATA_W-1:0] dev_wdata_o,
  input  logic                  dev_rvalid_i [`SS_NR_DEVICES],
  input  logic [`SS_DATA_W-1:0] dev_rdata_i  [`SS_NR_DEVICES],
  input  logic                  dev_err_i    [`SS_NR_DEVICES]
);

  import simple_system_pkg::*;

  bus_device_e dev_sel;
  bus_device_e dev_sel_q;
  logic        accept;
  logic        pending_q;

  // Address decode against the window table
  always_comb begin
    if ((host_addr_i & `SS_RAM_MASK) == `SS_RAM_BASE) begin
      dev_sel = Ram;
    end else if ((host_addr_i & `SS_SIMCTRL_MASK) == `SS_SIMCTRL_BASE) begin
      dev_sel = SimCtrl;
    end else if ((host_addr_i & `SS_TIMER_MASK) == `SS_TIMER_BASE) begin
      dev_sel = Timer;
    end else begin
      dev_sel = NoDevice;
    end
  end

  // Only one transaction in flight
  assign host_gnt_o = ~pending_q;
  assign accept     = host_req_i & host_gnt_o;

  always_comb begin
    for (int i = 0; i < `SS_NR_DEVICES; i++) begin
      dev_req_o[i] = accept && (dev_sel == bus_device_e'(i));
    end
  end

  // Request payload is shared by all devices
  assign dev_we_o    = host_we_i;
  assign dev_be_o    = host_be_i;
  assign dev_addr_o  = host_addr_i;
  assign dev_wdata_o = host_wdata_i;

  // Remember which device owes the response
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
      dev_sel_q <= NoDevice;
    end else begin
      pending_q <= accept;
      if (accept) begin
        dev_sel_q <= dev_sel;
      end
    end
  end

  // Response mux, unmapped accesses are answered here with an error
  always_comb begin
    host_rvalid_o = 1'b0;
    host_rdata_o  = '0;
    host_err_o    = 1'b0;
    if (dev_sel_q == NoDevice) begin
      host_rvalid_o = pending_q;
      host_err_o    = pending_q;
    end else begin
      host_rvalid_o = dev_rvalid_i[dev_sel_q];
      host_rdata_o  = dev_rdata_i[dev_sel_q];
      host_err_o    = dev_err_i[dev_sel_q];
    end
  end

endmodule

//--- design/sram_1p.sv
// Single-port SRAM

`timescale 1ns/1ps

`include "simple_system_defines.svh"

module sram_1p #(
  parameter int Depth = `SS_RAM_WORDS
) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [`SS_BE_W-1:0]   be_i,
  input  logic [`SS_ADDR_W-1:0] addr_i,
  input  logic [`SS_DATA_W-1:0] wdata_i,
  output logic                  rvalid_o,
  output logic [`SS_DATA_W-1:0] rdata_o
);

  localparam int AddrW = (Depth > 1) ? $clog2(Depth) : 1;

  logic [`SS_DATA_W-1:0] mem [Depth];
  logic [`SS_ADDR_W-3:0] word_full;
  logic [AddrW-1:0]      word_addr;

  // Word index, wraps at Depth
  assign word_full = addr_i[`SS_ADDR_W-1:2];
  assign word_addr = AddrW'(word_full % Depth);

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < `SS_BE_W; b++) begin
          if (be_i[b]) begin
            mem[word_addr][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
      // read-first, old data on a write
      rdata_o <= mem[word_addr];
    end
  end

  // Response one cycle after the request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

//--- design/sim_ctrl.sv
// Simulation control device

`timescale 1ns/1ps

`include "simple_system_defines.svh"

module sim_ctrl (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [`SS_BE_W-1:0]   be_i,
  input  logic [`SS_ADDR_W-1:0] addr_i,
  input  logic [`SS_DATA_W-1:0] wdata_i,
  output logic                  rvalid_o,
  output logic [`SS_DATA_W-1:0] rdata_o,

  output logic                  char_valid_o,
  output logic [7:0]            char_o,
  output logic                  halt_o
);

  import simple_system_pkg::*;

  logic [9:0]            offset;
  logic [`SS_DATA_W-1:0] wmask;
  logic                  wr_char;
  logic                  wr_halt;

  assign offset = addr_i[9:0];

  always_comb begin
    for (int b = 0; b < `SS_BE_W; b++) begin
      wmask[8*b +: 8] = {8{be_i[b]}};
    end
  end

  // Character needs byte 0 enabled, halt needs any enabled nonzero byte
  assign wr_char = req_i & we_i & be_i[0] & (offset == CharOut);
  assign wr_halt = req_i & we_i & (offset == Halt) & (|(wdata_i & wmask));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o     <= 1'b0;
      char_valid_o <= 1'b0;
      halt_o       <= 1'b0;
    end else begin
      rvalid_o     <= req_i;
      char_valid_o <= wr_char;
      if (wr_halt) begin
        halt_o <= 1'b1;
      end
    end
  end

  // Character byte and read data
  always_ff @(posedge clk_i) begin
    if (wr_char) begin
      char_o <= wdata_i[7:0];
    end
    if (req_i) begin
      rdata_o <= (!we_i && offset == Halt) ? `SS_DATA_W'(halt_o) : '0;
    end
  end

endmodule

//--- design/machine_timer.sv
// Machine timer

`timescale 1ns/1ps

`include "simple_system_defines.svh"

module machine_timer (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [`SS_BE_W-1:0]   be_i,
  input  logic [`SS_ADDR_W-1:0] addr_i,
  input  logic [`SS_DATA_W-1:0] wdata_i,
  output logic                  rvalid_o,
  output logic [`SS_DATA_W-1:0] rdata_o,
  output logic                  err_o,

  output logic                  timer_irq_o
);

  import simple_system_pkg::*;

  localparam int W = `SS_DATA_W;

  logic [9:0]     offset;
  logic           reg_hit;
  logic           wr;
  logic [W-1:0]   wmask;
  logic [2*W-1:0] mtime_q;
  logic [2*W-1:0] mtime_d;
  logic [2*W-1:0] mtimecmp_q;
  logic [2*W-1:0] mtimecmp_d;

  assign offset  = addr_i[9:0];
  assign reg_hit = offset inside {MtimeLo, MtimeHi, MtimecmpLo, MtimecmpHi};
  assign wr      = req_i & we_i & reg_hit;

  always_comb begin
    for (int b = 0; b < `SS_BE_W; b++) begin
      wmask[8*b +: 8] = {8{be_i[b]}};
    end
  end

  // Next-state with byte-merged writes, a mtime write wins over the increment
  always_comb begin
    mtime_d    = mtime_q + 1'b1;
    mtimecmp_d = mtimecmp_q;
    if (wr) begin
      case (offset)
        MtimeLo: mtime_d = {mtime_q[2*W-1:W], (mtime_q[W-1:0] & ~wmask) | (wdata_i & wmask)};
        MtimeHi: mtime_d = {(mtime_q[2*W-1:W] & ~wmask) | (wdata_i & wmask), mtime_q[W-1:0]};
        MtimecmpLo: begin
          mtimecmp_d[W-1:0] = (mtimecmp_q[W-1:0] & ~wmask) | (wdata_i & wmask);
        end
        MtimecmpHi: begin
          mtimecmp_d[2*W-1:W] = (mtimecmp_q[2*W-1:W] & ~wmask) | (wdata_i & wmask);
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      timer_irq_o <= 1'b0;
      rvalid_o    <= 1'b0;
      err_o       <= 1'b0;
    end else begin
      mtime_q     <= mtime_d;
      mtimecmp_q  <= mtimecmp_d;
      timer_irq_o <= (mtime_q >= mtimecmp_q);
      rvalid_o    <= req_i;
      err_o       <= req_i & ~reg_hit;
    end
  end

  // Register read, zero for unknown offsets
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      case (offset)
        MtimeLo:    rdata_o <= mtime_q[W-1:0];
        MtimeHi:    rdata_o <= mtime_q[2*W-1:W];
        MtimecmpLo: rdata_o <= mtimecmp_q[W-1:0];
        MtimecmpHi: rdata_o <= mtimecmp_q[2*W-1:W];
        default:    rdata_o <= '0;
      endcase
    end
  end

endmodule

//--- design/simple_system.sv
// Simple memory-mapped system

`timescale 1ns/1ps

`include "simple_system_defines.svh"

module simple_system (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  host_req_i,
  input  logic                  host_we_i,
  input  logic [`SS_BE_W-1:0]   host_be_i,
  input  logic [`SS_ADDR_W-1:0] host_addr_i,
  input  logic [`SS_DATA_W-1:0] host_wdata_i,
  output logic                  host_gnt_o,
  output logic                  host_rvalid_o,
  output logic [`SS_DATA_W-1:0] host_rdata_o,
  output logic                  host_err_o,

  output logic                  char_valid_o,
  output logic [7:0]            char_o,
  output logic                  halt_o,
  output logic                  timer_irq_o
);

  import simple_system_pkg::*;

  // Device side of the bus
  logic                  dev_req    [`SS_NR_DEVICES];
  logic                  dev_rvalid [`SS_NR_DEVICES];
  logic [`SS_DATA_W-1:0] dev_rdata  [`SS_NR_DEVICES];
  logic                  dev_err    [`SS_NR_DEVICES];
  logic                  dev_we;
  logic [`SS_BE_W-1:0]   dev_be;
  logic [`SS_ADDR_W-1:0] dev_addr;
  logic [`SS_DATA_W-1:0] dev_wdata;

  // RAM and control device never flag errors
  assign dev_err[Ram]     = 1'b0;
  assign dev_err[SimCtrl] = 1'b0;

  system_bus u_bus (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .host_req_i    (host_req_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_addr_i   (host_addr_i),
    .host_wdata_i  (host_wdata_i),
    .host_gnt_o    (host_gnt_o),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .dev_req_o     (dev_req),
    .dev_we_o      (dev_we),
    .dev_be_o      (dev_be),
    .dev_addr_o    (dev_addr),
    .dev_wdata_o   (dev_wdata),
    .dev_rvalid_i  (dev_rvalid),
    .dev_rdata_i   (dev_rdata),
    .dev_err_i     (dev_err)
  );

  sram_1p #(
    .Depth (`SS_RAM_WORDS)
  ) u_ram (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (dev_req[Ram]),
    .we_i     (dev_we),
    .be_i     (dev_be),
    .addr_i   (dev_addr),
    .wdata_i  (dev_wdata),
    .rvalid_o (dev_rvalid[Ram]),
    .rdata_o  (dev_rdata[Ram])
  );

  sim_ctrl u_sim_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (dev_req[SimCtrl]),
    .we_i         (dev_we),
    .be_i         (dev_be),
    .addr_i       (dev_addr),
    .wdata_i      (dev_wdata),
    .rvalid_o     (dev_rvalid[SimCtrl]),
    .rdata_o      (dev_rdata[SimCtrl]),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

  machine_timer u_timer (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (dev_req[Timer]),
    .we_i        (dev_we),
    .be_i        (dev_be),
    .addr_i      (dev_addr),
    .wdata_i     (dev_wdata),
    .rvalid_o    (dev_rvalid[Timer]),
    .rdata_o     (dev_rdata[Timer]),
    .err_o       (dev_err[Timer]),
    .timer_irq_o (timer_irq_o)
  );

endmodule

//--- bench/simple_system_tb.sv
// Simple system testbench

`timescale 1ns/1ps

`include "simple_system_defines.svh"

module simple_system_tb;

  import simple_system_pkg::*;

  typedef struct {
    logic                  we;
    logic [`SS_ADDR_W-1:0] addr;
    logic [`SS_BE_W-1:0]   be;
    logic [`SS_DATA_W-1:0] wdata;
    logic [`SS_DATA_W-1:0] exp_rdata;
    logic                  exp_err;
    logic                  chk_rdata;
  } access_t;

  logic                  clk_i;
  logic                  reset_i;
  logic                  host_req_i;
  logic                  host_we_i;
  logic [`SS_BE_W-1:0]   host_be_i;
  logic [`SS_ADDR_W-1:0] host_addr_i;
  logic [`SS_DATA_W-1:0] host_wdata_i;
  logic                  host_gnt_o;
  logic                  host_rvalid_o;
  logic [`SS_DATA_W-1:0] host_rdata_o;
  logic                  host_err_o;
  logic                  char_valid_o;
  logic [7:0]            char_o;
  logic                  halt_o;
  logic                  timer_irq_o;

  access_t               tbl [$];
  logic [7:0]            exp_chars [$];
  logic [`SS_DATA_W-1:0] ram_model [`SS_RAM_WORDS];
  int                    mismatches = 0;
  int                    failures = 0;
  int                    char_count = 0;
  int                    chars_expected = 0;
  bit                    table_ready = 0;

  simple_system simple_system_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Word index in the RAM, high address bits wrap at the depth
  function automatic int ram_index(logic [`SS_ADDR_W-1:0] addr);
    return (addr >> 2) % `SS_RAM_WORDS;
  endfunction

  function automatic void add_access(logic we, logic [31:0] addr, logic [3:0] be,
                                     logic [31:0] wdata, logic [31:0] exp_rdata,
                                     logic exp_err, logic chk_rdata);
    access_t a;
    a.we = we;
    a.addr = addr;
    a.be = be;
    a.wdata = wdata;
    a.exp_rdata = exp_rdata;
    a.exp_err = exp_err;
    a.chk_rdata = chk_rdata;
    tbl.push_back(a);
  endfunction

  function automatic void add_ram_write(logic [31:0] offs, logic [3:0] be, logic [31:0] data);
    int idx;
    idx = ram_index(`SS_RAM_BASE + offs);
    for (int b = 0; b < `SS_BE_W; b++) begin
      if (be[b]) ram_model[idx][8*b +: 8] = data[8*b +: 8];
    end
    add_access(1'b1, `SS_RAM_BASE + offs, be, data, '0, 1'b0, 1'b0);
  endfunction

  function automatic void add_ram_read(logic [31:0] offs);
    add_access(1'b0, `SS_RAM_BASE + offs, 4'hF, '0,
               ram_model[ram_index(`SS_RAM_BASE + offs)], 1'b0, 1'b1);
  endfunction

  function automatic void add_char_write(logic [7:0] ch);
    exp_chars.push_back(ch);
    add_access(1'b1, `SS_SIMCTRL_BASE + 32'(CharOut), 4'hF,
               {24'($urandom), ch}, '0, 1'b0, 1'b0);
  endfunction

  function automatic void build_table();
    for (int k = 0; k < 4; k++) add_ram_write(4*k, 4'hF, $urandom);
    add_ram_write(32'h0, 4'b0001, $urandom);
    add_ram_write(32'h4, 4'b0110, $urandom);
    add_ram_write(32'h8, 4'b1000, $urandom);
    add_ram_write(32'hC, 4'b0101, $urandom);
    for (int k = 0; k < 4; k++) add_ram_read(4*k);
    // Beyond the depth, lands on word 8
    add_ram_write(`SS_RAM_WORDS*4 + 32'h20, 4'hF, $urandom);
    add_ram_read(32'h20);
    // Unmapped, word 0 must survive the stray write
    add_access(1'b0, 32'h0000_1000, 4'hF, '0, '0, 1'b1, 1'b1);
    add_access(1'b1, 32'h0000_0000, 4'hF, $urandom, '0, 1'b1, 1'b1);
    add_access(1'b0, `SS_SIMCTRL_BASE + 32'h400, 4'hF, '0, '0, 1'b1, 1'b1);
    add_ram_read(32'h0);
    add_char_write("O");
    add_char_write("K");
    add_char_write("!");
    add_access(1'b0, `SS_SIMCTRL_BASE + 32'(Halt), 4'hF, '0, 32'd0, 1'b0, 1'b1);
    add_access(1'b1, `SS_SIMCTRL_BASE + 32'(Halt), 4'hF, 32'd1, '0, 1'b0, 1'b0);
    add_access(1'b0, `SS_SIMCTRL_BASE + 32'(Halt), 4'hF, '0, 32'd1, 1'b0, 1'b1);
    add_access(1'b0, `SS_TIMER_BASE + 32'h10, 4'hF, '0, '0, 1'b1, 1'b0);
  endfunction

  // One host transaction, outputs sampled on the falling edge
  task automatic run_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge clk_i);
    host_req_i   <= 1'b1;
    host_we_i    <= we;
    host_be_i    <= be;
    host_addr_i  <= addr;
    host_wdata_i <= wdata;
    @(negedge clk_i);
    while (!host_gnt_o) @(negedge clk_i);
    @(posedge clk_i);
    host_req_i <= 1'b0;
    @(negedge clk_i);
    // Response is due in the cycle right after acceptance
    if (!host_rvalid_o) begin
      $display("No response in the cycle after the request was accepted");
      failures++;
    end
    while (!host_rvalid_o) @(negedge clk_i);
    if (host_gnt_o) begin
      $display("MISMATCH at %0t: gnt high while a response is pending", $time);
      mismatches++;
    end
    rdata = host_rdata_o;
    err   = host_err_o;
  endtask

  task automatic timer_access(input logic we, input timer_reg_e reg_offs,
                              input logic [31:0] wdata, output logic [31:0] rdata);
    logic err;
    run_access(we, `SS_TIMER_BASE + 32'(reg_offs), 4'hF, wdata, rdata, err);
    if (err) begin
      $display("Timer access at offset %h returned an error", reg_offs);
      failures++;
    end
  endtask

  // Character monitor
  always @(negedge clk_i) begin
    if (!reset_i && char_valid_o) begin
      char_count++;
      if (exp_chars.size() == 0) begin
        $display("Character strobe with no character expected");
        failures++;
      end else begin
        if (char_o !== exp_chars[0]) begin
          $display("MISMATCH at %0t: char %h expected %h", $time, char_o, exp_chars[0]);
          mismatches++;
        end
        void'(exp_chars.pop_front());
      end
    end
  end

  initial begin
    wait (table_ready);
    repeat (tbl.size() * 20 + 2000) @(posedge clk_i);
    $display("Timeout, the run did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    logic [31:0] rdata;
    logic        err;
    logic [31:0] t1;
    logic [31:0] t2;
    int          cycles;
    reset_i      = 1'b1;
    host_req_i   = 1'b0;
    host_we_i    = 1'b0;
    host_be_i    = '0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    void'($urandom(73));
    build_table();
    chars_expected = exp_chars.size();
    table_ready = 1;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    if (host_rvalid_o || host_err_o || char_valid_o || halt_o || timer_irq_o) begin
      $display("Outputs not inactive after reset");
      failures++;
    end

    foreach (tbl[i]) begin
      run_access(tbl[i].we, tbl[i].addr, tbl[i].be, tbl[i].wdata, rdata, err);
      if (err !== tbl[i].exp_err) begin
        $display("MISMATCH at %0t: entry %0d err %b expected %b", $time, i, err,
                 tbl[i].exp_err);
        mismatches++;
      end
      if (tbl[i].chk_rdata && rdata !== tbl[i].exp_rdata) begin
        $display("MISMATCH at %0t: entry %0d rdata %h expected %h", $time, i, rdata,
                 tbl[i].exp_rdata);
        mismatches++;
      end
    end

    // mtime runs, the interrupt follows the compare value
    timer_access(1'b0, MtimeLo, '0, t1);
    timer_access(1'b0, MtimeLo, '0, t2);
    if (t2 <= t1) begin
      $display("MISMATCH at %0t: mtime %h not above %h", $time, t2, t1);
      mismatches++;
    end
    if (timer_irq_o) begin
      $display("Timer interrupt high while mtimecmp is all ones");
      failures++;
    end
    timer_access(1'b1, MtimecmpLo, t2 + 32'd50, rdata);
    timer_access(1'b1, MtimecmpHi, 32'd0, rdata);
    if (timer_irq_o) begin
      $display("Timer interrupt rose before mtime reached mtimecmp");
      failures++;
    end
    cycles = 0;
    while (!timer_irq_o && cycles < 60) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!timer_irq_o) begin
      $display("Timer interrupt did not rise within 60 cycles");
      failures++;
    end
    timer_access(1'b1, MtimecmpHi, 32'hFFFF_FFFF, rdata);
    cycles = 0;
    while (timer_irq_o && cycles < 2) begin
      @(negedge clk_i);
      cycles++;
    end
    if (timer_irq_o) begin
      $display("Timer interrupt did not fall within 2 cycles");
      failures++;
    end

    if (!halt_o) begin
      $display("Halt flag did not stay high");
      failures++;
    end
    if (char_count != chars_expected) begin
      $display("Saw %0d character strobes, expected %0d", char_count, chars_expected);
      failures++;
    end

    $display("Mismatches: %0d, other errors: %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- simple_system.f
+incdir+design
design/simple_system_pkg.sv
design/system_bus.sv
design/sram_1p.sv
design/sim_ctrl.sv
design/machine_timer.sv
design/simple_system.sv
bench/simple_system_tb.sv

//--- Bender.yml
package:
  name: simple_system

export_include_dirs:
  - design

sources:
  - files:
      - design/simple_system_pkg.sv
      - design/system_bus.sv
      - design/sram_1p.sv
      - design/sim_ctrl.sv
      - design/machine_timer.sv
      - design/simple_system.sv
  - target: simulation
    files:
      - bench/simple_system_tb.sv
